// File: verilog/rv_isa_pkg.sv
// rv_isa_pkg: RV32I subset opcodes, funct codes, ALU operation codes, instruction union
`default_nettype none

package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    // funct fields
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_word    = 3'b010;
    localparam logic [6:0] f7_sub     = 7'b0100000;

    // alu operations
    localparam int unsigned alu_w = 3;
    localparam logic [alu_w-1:0] alu_add = 3'd0;
    localparam logic [alu_w-1:0] alu_sub = 3'd1;
    localparam logic [alu_w-1:0] alu_and = 3'd2;
    localparam logic [alu_w-1:0] alu_or  = 3'd3;
    localparam logic [alu_w-1:0] alu_xor = 3'd4;
    localparam logic [alu_w-1:0] alu_slt = 3'd5;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // store immediate is split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } instr_t;

endpackage

`default_nettype wire

// File: verilog/core_cfg_pkg.sv
// core_cfg_pkg: memory size, word address width, reset program counter
`default_nettype none

package core_cfg_pkg;

    // unified memory, one 32-bit word per address
    localparam int unsigned mem_words = 256;
    localparam int unsigned addr_w    = 8;

    // pc counts words, not bytes
    localparam logic [addr_w-1:0] reset_pc = '0;

endpackage

`default_nettype wire

// File: verilog/fetch_stage.sv
// fetch_stage: program counter and IF/ID register
`default_nettype none

module fetch_stage (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         run,
    input  logic                         stall,
    input  logic                         fetch_grant,
    input  logic [31:0]                  mem_rdata,
    output logic                         fetch_req,
    output logic [core_cfg_pkg::addr_w-1:0] fetch_addr,
    output rv_isa_pkg::instr_t           if_instr,
    output logic                         if_valid
);
    import core_cfg_pkg::*;

    logic [addr_w-1:0] pc;

    assign fetch_req  = run;
    assign fetch_addr = pc;

    // stall freezes pc and IF/ID, a lost grant injects a bubble
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc       <= reset_pc;
            if_valid <= 1'b0;
        end else if (!stall) begin
            if_valid <= fetch_grant;
            if (fetch_grant) begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && fetch_grant) begin
            if_instr <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
// decode_stage: field decode, control generation, load-use hazard detection
`default_nettype none

module decode_stage (
    input  rv_isa_pkg::instr_t             if_instr,
    input  logic                           if_valid,
    input  logic                           ex_memread,
    input  logic [4:0]                     ex_rd,
    input  logic [31:0]                    rs1_data,
    input  logic [31:0]                    rs2_data,
    output logic [4:0]                     rs1_addr,
    output logic [4:0]                     rs2_addr,
    output logic [4:0]                     rd,
    output logic [31:0]                    imm,
    output logic [rv_isa_pkg::alu_w-1:0]   alu_op,
    output logic                           has_imm,
    output logic                           regwrite,
    output logic                           memread,
    output logic                           memwrite,
    output logic                           stall,
    output logic [31:0]                    op_a,
    output logic [31:0]                    op_b_reg
);
    import rv_isa_pkg::*;

    logic        dec_wr;
    logic        use_rs1;
    logic        use_rs2;
    logic [31:0] i_imm;
    logic [31:0] s_imm;

    assign rs1_addr = if_instr.r_fmt.rs1;
    assign rs2_addr = if_instr.r_fmt.rs2;
    assign rd       = if_instr.r_fmt.rd;
    assign op_a     = rs1_data;
    assign op_b_reg = rs2_data;

    assign i_imm = {{20{if_instr.i_fmt.imm[11]}}, if_instr.i_fmt.imm};
    assign s_imm = {{20{if_instr.s_fmt.imm_hi[6]}}, if_instr.s_fmt.imm_hi,
                    if_instr.s_fmt.imm_lo};

    ////////////////////////////////////////////////////////////
    // control decode, anything unsupported is a no-op
    ////////////////////////////////////////////////////////////
    always_comb begin
        alu_op   = alu_add;
        has_imm  = 1'b0;
        dec_wr   = 1'b0;
        memread  = 1'b0;
        memwrite = 1'b0;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        imm      = i_imm;
        if (if_valid) begin
            case (if_instr.r_fmt.opcode)
                opc_op: begin
                    dec_wr  = 1'b1;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    case (if_instr.r_fmt.funct3)
                        f3_add_sub: alu_op = (if_instr.r_fmt.funct7 == f7_sub) ? alu_sub
                                                                               : alu_add;
                        f3_slt:  alu_op = alu_slt;
                        f3_xor:  alu_op = alu_xor;
                        f3_or:   alu_op = alu_or;
                        f3_and:  alu_op = alu_and;
                        default: begin
                            dec_wr  = 1'b0;
                            use_rs1 = 1'b0;
                            use_rs2 = 1'b0;
                        end
                    endcase
                end
                opc_op_imm: if (if_instr.r_fmt.funct3 == f3_add_sub) begin
                    dec_wr  = 1'b1;
                    use_rs1 = 1'b1;
                    has_imm = 1'b1;
                end
                opc_load: if (if_instr.r_fmt.funct3 == f3_word) begin
                    dec_wr  = 1'b1;
                    memread = 1'b1;
                    use_rs1 = 1'b1;
                    has_imm = 1'b1;
                end
                opc_store: if (if_instr.r_fmt.funct3 == f3_word) begin
                    memwrite = 1'b1;
                    use_rs1  = 1'b1;
                    use_rs2  = 1'b1;
                    has_imm  = 1'b1;
                    imm      = s_imm;
                end
                default: ;
            endcase
        end
    end

    // x0 is never a real destination
    assign regwrite = dec_wr && (rd != 5'd0);

    // load in EX feeding the instruction in ID
    assign stall = ex_memread && (ex_rd != 5'd0) &&
                   ((use_rs1 && (rs1_addr == ex_rd)) || (use_rs2 && (rs2_addr == ex_rd)));

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
// reg_file: 32x32 register file, two read ports, one write port
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rstn,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic        wb_we,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && (wb_rd != 5'd0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle write is visible to the reader
    assign rs1_data = (rs1_addr == 5'd0) ? '0 :
                      (wb_we && (wb_rd == rs1_addr)) ? wb_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 :
                      (wb_we && (wb_rd == rs2_addr)) ? wb_data : regs[rs2_addr];

endmodule

`default_nettype wire

// File: verilog/id_ex_reg.sv
// id_ex_reg: ID/EX pipeline register with bubble insertion
`default_nettype none

module id_ex_reg (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         bubble,
    input  logic [4:0]                   rs1_addr,
    input  logic [4:0]                   rs2_addr,
    input  logic [4:0]                   rd,
    input  logic [31:0]                  imm,
    input  logic [rv_isa_pkg::alu_w-1:0] alu_op,
    input  logic                         has_imm,
    input  logic                         regwrite,
    input  logic                         memread,
    input  logic                         memwrite,
    input  logic [31:0]                  op_a,
    input  logic [31:0]                  op_b_reg,
    output logic [4:0]                   ex_rs1_addr,
    output logic [4:0]                   ex_rs2_addr,
    output logic [4:0]                   ex_rd,
    output logic [31:0]                  ex_imm,
    output logic [rv_isa_pkg::alu_w-1:0] ex_alu_op,
    output logic                         ex_has_imm,
    output logic                         ex_regwrite,
    output logic                         ex_memread,
    output logic                         ex_memwrite,
    output logic [31:0]                  ex_op_a,
    output logic [31:0]                  ex_op_b_reg
);

    // controls, cleared by reset or a bubble
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex_regwrite <= 1'b0;
            ex_memread  <= 1'b0;
            ex_memwrite <= 1'b0;
        end else begin
            ex_regwrite <= regwrite && !bubble;
            ex_memread  <= memread && !bubble;
            ex_memwrite <= memwrite && !bubble;
        end
    end

    // operands and fields
    always_ff @(posedge clk) begin
        ex_rs1_addr <= rs1_addr;
        ex_rs2_addr <= rs2_addr;
        ex_rd       <= rd;
        ex_imm      <= imm;
        ex_alu_op   <= alu_op;
        ex_has_imm  <= has_imm;
        ex_op_a     <= op_a;
        ex_op_b_reg <= op_b_reg;
    end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
// execute_stage: operand forwarding, ALU, address generation, EX/MEM register
`default_nettype none

module execute_stage (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic [4:0]                   ex_rs1_addr,
    input  logic [4:0]                   ex_rs2_addr,
    input  logic [4:0]                   ex_rd,
    input  logic [31:0]                  ex_imm,
    input  logic [rv_isa_pkg::alu_w-1:0] ex_alu_op,
    input  logic                         ex_has_imm,
    input  logic                         ex_regwrite,
    input  logic                         ex_memread,
    input  logic                         ex_memwrite,
    input  logic [31:0]                  ex_op_a,
    input  logic [31:0]                  ex_op_b_reg,
    input  logic                         wb_we,
    input  logic [4:0]                   wb_rd,
    input  logic [31:0]                  wb_data,
    output logic [4:0]                   mem_rd,
    output logic [31:0]                  mem_result,
    output logic [31:0]                  mem_store_data,
    output logic                         mem_regwrite,
    output logic                         mem_memread,
    output logic                         mem_memwrite
);
    import rv_isa_pkg::*;

    logic [31:0] fwd_a;
    logic [31:0] fwd_b;
    logic [31:0] alu_b;
    logic [31:0] alu_y;

    // newest producer wins, a load in MEM has only its address here
    function automatic logic [31:0] fwd(input logic [4:0] src, input logic [31:0] reg_val);
        if (mem_regwrite && !mem_memread && (mem_rd != 5'd0) && (mem_rd == src)) begin
            return mem_result;
        end
        if (wb_we && (wb_rd != 5'd0) && (wb_rd == src)) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    assign fwd_a = fwd(ex_rs1_addr, ex_op_a);
    assign fwd_b = fwd(ex_rs2_addr, ex_op_b_reg);
    assign alu_b = ex_has_imm ? ex_imm : fwd_b;

    ////////////////////////////////////////////////////////////
    // alu, also forms the byte address for LW/SW
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (ex_alu_op)
            alu_sub: alu_y = fwd_a - alu_b;
            alu_and: alu_y = fwd_a & alu_b;
            alu_or:  alu_y = fwd_a | alu_b;
            alu_xor: alu_y = fwd_a ^ alu_b;
            alu_slt: alu_y = {31'd0, $signed(fwd_a) < $signed(alu_b)};
            default: alu_y = fwd_a + alu_b;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_regwrite <= 1'b0;
            mem_memread  <= 1'b0;
            mem_memwrite <= 1'b0;
        end else begin
            mem_regwrite <= ex_regwrite;
            mem_memread  <= ex_memread;
            mem_memwrite <= ex_memwrite;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd         <= ex_rd;
        mem_result     <= alu_y;
        mem_store_data <= fwd_b;
    end

endmodule

`default_nettype wire

// File: verilog/mem_stage.sv
// mem_stage: data memory access, load capture, MEM/WB register
`default_nettype none

module mem_stage (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [4:0]                      mem_rd,
    input  logic [31:0]                     mem_result,
    input  logic [31:0]                     mem_store_data,
    input  logic                            mem_regwrite,
    input  logic                            mem_memread,
    input  logic                            mem_memwrite,
    input  logic                            data_grant,
    input  logic [31:0]                     mem_rdata,
    output logic                            data_req,
    output logic                            data_we,
    output logic [core_cfg_pkg::addr_w-1:0] data_addr,
    output logic [31:0]                     data_wdata,
    output logic                            wb_we,
    output logic [4:0]                      wb_rd,
    output logic [31:0]                     wb_data
);
    import core_cfg_pkg::*;

    assign data_req   = mem_memread || mem_memwrite;
    assign data_we    = mem_memwrite;
    // byte address to word address
    assign data_addr  = mem_result[addr_w+1:2];
    assign data_wdata = mem_store_data;

    // a load only writes back once its read was granted
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_regwrite && (!mem_memread || data_grant);
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_memread ? mem_rdata : mem_result;
    end

endmodule

`default_nettype wire

// File: verilog/mem_arbiter.sv
// mem_arbiter: fixed-priority arbiter for loader, data and fetch requesters
`default_nettype none

module mem_arbiter (
    input  logic                            load_req,
    input  logic                            load_we,
    input  logic [core_cfg_pkg::addr_w-1:0] load_addr,
    input  logic [31:0]                     load_wdata,
    input  logic                            data_req,
    input  logic                            data_we,
    input  logic [core_cfg_pkg::addr_w-1:0] data_addr,
    input  logic [31:0]                     data_wdata,
    input  logic                            fetch_req,
    input  logic [core_cfg_pkg::addr_w-1:0] fetch_addr,
    output logic                            load_grant,
    output logic                            data_grant,
    output logic                            fetch_grant,
    output logic                            mem_we,
    output logic [core_cfg_pkg::addr_w-1:0] mem_addr,
    output logic [31:0]                     mem_wdata
);

    // loader > data > fetch
    assign load_grant  = load_req;
    assign data_grant  = data_req && !load_req;
    assign fetch_grant = fetch_req && !load_req && !data_req;

    always_comb begin
        mem_we    = 1'b0;
        mem_addr  = fetch_addr;
        mem_wdata = '0;
        if (load_grant) begin
            mem_we    = load_we;
            mem_addr  = load_addr;
            mem_wdata = load_wdata;
        end else if (data_grant) begin
            mem_we    = data_we;
            mem_addr  = data_addr;
            mem_wdata = data_wdata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/unified_mem.sv
// unified_mem: single-port word memory, async read, sync write
`default_nettype none

module unified_mem (
    input  logic                            clk,
    input  logic                            mem_we,
    input  logic [core_cfg_pkg::addr_w-1:0] mem_addr,
    input  logic [31:0]                     mem_wdata,
    output logic [31:0]                     mem_rdata
);
    import core_cfg_pkg::*;

    logic [31:0] mem [mem_words];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    assign mem_rdata = mem[mem_addr];

endmodule

`default_nettype wire

// File: verilog/rv_core_top.sv
// rv_core_top: pipeline stages, memory arbiter and unified memory
`default_nettype none

module rv_core_top (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            run,
    input  logic                            load_req,
    input  logic                            load_we,
    input  logic [core_cfg_pkg::addr_w-1:0] load_addr,
    input  logic [31:0]                     load_wdata,
    output logic [31:0]                     load_rdata,
    output logic                            retire_valid,
    output logic [4:0]                      retire_rd,
    output logic [31:0]                     retire_data
);
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;

    ////////////////////////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////////////////////////
    logic              fetch_req, fetch_grant, if_valid, stall;
    logic [addr_w-1:0] fetch_addr;
    instr_t            if_instr;

    logic [4:0]        rs1_addr, rs2_addr, rd;
    logic [31:0]       imm, op_a, op_b_reg, rs1_data, rs2_data;
    logic [alu_w-1:0]  alu_op;
    logic              has_imm, regwrite, memread, memwrite;

    logic [4:0]        ex_rs1_addr, ex_rs2_addr, ex_rd;
    logic [31:0]       ex_imm, ex_op_a, ex_op_b_reg;
    logic [alu_w-1:0]  ex_alu_op;
    logic              ex_has_imm, ex_regwrite, ex_memread, ex_memwrite;

    logic [4:0]        mem_rd;
    logic [31:0]       mem_result, mem_store_data;
    logic              mem_regwrite, mem_memread, mem_memwrite;

    logic              data_req, data_we, data_grant, load_grant, mem_we;
    logic [addr_w-1:0] data_addr, mem_addr;
    logic [31:0]       data_wdata, mem_wdata, mem_rdata;

    logic              wb_we;
    logic [4:0]        wb_rd;
    logic [31:0]       wb_data;

    assign load_rdata   = load_grant ? mem_rdata : '0;
    assign retire_valid = wb_we;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

    fetch_stage u_fetch (
        .clk, .rstn, .run, .stall, .fetch_grant, .mem_rdata,
        .fetch_req, .fetch_addr, .if_instr, .if_valid
    );

    decode_stage u_decode (
        .if_instr, .if_valid, .ex_memread, .ex_rd, .rs1_data, .rs2_data,
        .rs1_addr, .rs2_addr, .rd, .imm, .alu_op, .has_imm,
        .regwrite, .memread, .memwrite, .stall, .op_a, .op_b_reg
    );

    reg_file u_rf (
        .clk, .rstn, .rs1_addr, .rs2_addr, .wb_we, .wb_rd, .wb_data,
        .rs1_data, .rs2_data
    );

    // a stalled instruction stays in ID, EX gets a bubble
    id_ex_reg u_id_ex (
        .clk, .rstn, .bubble(stall),
        .rs1_addr, .rs2_addr, .rd, .imm, .alu_op, .has_imm,
        .regwrite, .memread, .memwrite, .op_a, .op_b_reg,
        .ex_rs1_addr, .ex_rs2_addr, .ex_rd, .ex_imm, .ex_alu_op, .ex_has_imm,
        .ex_regwrite, .ex_memread, .ex_memwrite, .ex_op_a, .ex_op_b_reg
    );

    execute_stage u_ex (
        .clk, .rstn,
        .ex_rs1_addr, .ex_rs2_addr, .ex_rd, .ex_imm, .ex_alu_op, .ex_has_imm,
        .ex_regwrite, .ex_memread, .ex_memwrite, .ex_op_a, .ex_op_b_reg,
        .wb_we, .wb_rd, .wb_data,
        .mem_rd, .mem_result, .mem_store_data,
        .mem_regwrite, .mem_memread, .mem_memwrite
    );

    mem_stage u_mem (
        .clk, .rstn, .mem_rd, .mem_result, .mem_store_data,
        .mem_regwrite, .mem_memread, .mem_memwrite, .data_grant, .mem_rdata,
        .data_req, .data_we, .data_addr, .data_wdata, .wb_we, .wb_rd, .wb_data
    );

    mem_arbiter u_arb (
        .load_req, .load_we, .load_addr, .load_wdata,
        .data_req, .data_we, .data_addr, .data_wdata,
        .fetch_req, .fetch_addr,
        .load_grant, .data_grant, .fetch_grant, .mem_we, .mem_addr, .mem_wdata
    );

    unified_mem u_ram (
        .clk, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

endmodule

`default_nettype wire

// File: sim/tb_rv_core.sv
// random program generator, instruction-set model, retire and memory checker
`default_nettype none

module tb_rv_core;
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;

    localparam int prog_len   = 60;
    localparam int run_budget = prog_len * 3 + 20;
    localparam int data_lo    = 128;
    localparam int data_hi    = 191;
    localparam logic [31:0] seed = 32'h9e536509;

    logic              clk;
    logic              rstn;
    logic              run;
    logic              load_req;
    logic              load_we;
    logic [addr_w-1:0] load_addr;
    logic [31:0]       load_wdata;
    logic [31:0]       load_rdata;
    logic              retire_valid;
    logic [4:0]        retire_rd;
    logic [31:0]       retire_data;

    logic [31:0] rng;
    logic [31:0] image [mem_words];
    logic [31:0] model_mem [mem_words];
    logic [31:0] model_regs [32];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_val_q [$];
    int          exp_total = 0;
    int          retired_cnt = 0;
    int          run_cycles = 0;

    rv_core_top dut_i (
        .clk, .rstn, .run, .load_req, .load_we, .load_addr, .load_wdata,
        .load_rdata, .retire_valid, .retire_rd, .retire_data
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 3 random bits onto x1..x7
    function automatic logic [4:0] pick_reg(input logic [2:0] x);
        return (x == 3'd0) ? 5'd7 : {2'b00, x};
    endfunction

    // op 0 to 5 selects add, sub, and, or, xor, slt
    function automatic logic [31:0] enc_r(input logic [2:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = 7'd0;
        case (op)
            3'd0: f3 = 3'b000;
            3'd1: begin
                f3 = 3'b000;
                f7 = 7'b0100000;
            end
            3'd2: f3 = 3'b111;
            3'd3: f3 = 3'b110;
            3'd4: f3 = 3'b100;
            default: f3 = 3'b010;
        endcase
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            3'd0: return a + b;
            3'd1: return a - b;
            3'd2: return a & b;
            3'd3: return a | b;
            3'd4: return a ^ b;
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic halt_on_failure();
        $display("TB FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            halt_on_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // program image and in-order model
    ////////////////////////////////////////////////////////////
    task automatic build_program();
        logic [31:0] r;
        logic [31:0] word;
        logic [31:0] val;
        logic [3:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [11:0] ofs;
        logic [7:0]  daddr;
        logic        wr;
        for (int a = 0; a < mem_words; a++) begin
            image[a] = '0;
            model_mem[a] = '0;
        end
        for (int a = data_lo; a <= data_hi; a++) begin
            rng = xorshift(rng);
            image[a] = rng;
            model_mem[a] = rng;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < prog_len; i++) begin
            rng   = xorshift(rng);
            r     = rng;
            sel   = r[3:0];
            rd    = {2'b00, r[6:4]};
            rs1   = pick_reg(r[10:8]);
            rs2   = pick_reg(r[13:11]);
            imm   = r[25:14];
            daddr = 8'd128 + {2'b00, r[31:26]};
            ofs   = {2'b00, daddr, 2'b00};
            // last one always writes, so its retire ends the run
            if (i == prog_len - 1) begin
                sel = 4'd14;
                rd  = pick_reg(r[6:4]);
            end
            wr  = 1'b0;
            val = '0;
            if (sel < 4'd6) begin
                word = enc_r(sel[2:0], rd, rs1, rs2);
                val  = alu_ref(sel[2:0], model_regs[rs1], model_regs[rs2]);
                wr   = 1'b1;
            end else if (sel < 4'd9 || sel >= 4'd14) begin
                word = {imm, rs1, 3'b000, rd, opc_op_imm};
                val  = model_regs[rs1] + {{20{imm[11]}}, imm};
                wr   = 1'b1;
            end else if (sel < 4'd11) begin
                word = {ofs, 5'd0, 3'b010, rd, opc_load};
                val  = model_mem[daddr];
                wr   = 1'b1;
            end else if (sel < 4'd13) begin
                word = {ofs[11:5], rs2, 5'd0, 3'b010, ofs[4:0], opc_store};
                model_mem[daddr] = model_regs[rs2];
            end else begin
                word = '0;
            end
            // x0 never retires
            if (wr && rd != 5'd0) begin
                model_regs[rd] = val;
                exp_rd_q.push_back(rd);
                exp_val_q.push_back(val);
                exp_total++;
            end
            image[i] = word;
        end
    endtask

    task automatic write_word(input logic [addr_w-1:0] addr, input logic [31:0] data);
        load_req   = 1'b1;
        load_we    = 1'b1;
        load_addr  = addr;
        load_wdata = data;
        @(posedge clk);
        #1;
    endtask

    task automatic read_word(input logic [addr_w-1:0] addr, output logic [31:0] data);
        load_req  = 1'b1;
        load_we   = 1'b0;
        load_addr = addr;
        @(negedge clk);
        data = load_rdata;
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // retire monitor and cycle limit
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rstn && retire_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("retire of x%0d at %0t with no write left in the model",
                         retire_rd, $time);
                halt_on_failure();
            end else begin
                check_equal({27'd0, retire_rd}, {27'd0, exp_rd_q[0]}, "retire rd");
                check_equal(retire_data, exp_val_q[0], "retire data");
                exp_rd_q.delete(0);
                exp_val_q.delete(0);
                retired_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        if (run) begin
            run_cycles++;
            if (run_cycles > run_budget) begin
                $display("timeout: only %0d of %0d retires after %0d cycles",
                         retired_cnt, exp_total, run_budget);
                halt_on_failure();
            end
        end
    end

    initial begin
        logic [31:0] rdata;
        clk        = 1'b0;
        rstn       = 1'b0;
        run        = 1'b0;
        load_req   = 1'b0;
        load_we    = 1'b0;
        load_addr  = '0;
        load_wdata = '0;
        rng        = seed;
        build_program();
        $display("program of %0d words, %0d register writes expected", prog_len, exp_total);

        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;

        // program, data and zero padding through the loader
        for (int a = 0; a < mem_words; a++) begin
            write_word(a[addr_w-1:0], image[a]);
        end
        load_req = 1'b0;
        load_we  = 1'b0;
        run      = 1'b1;

        while (retired_cnt < exp_total) begin
            @(posedge clk);
        end
        #1;
        run = 1'b0;
        // drain trailing bubbles
        repeat (6) @(posedge clk);
        #1;

        for (int a = data_lo; a <= data_hi; a++) begin
            read_word(a[addr_w-1:0], rdata);
            check_equal(rdata, model_mem[a], $sformatf("data word %0d", a));
        end
        load_req = 1'b0;

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
verilog/rv_isa_pkg.sv
verilog/core_cfg_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/id_ex_reg.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/mem_arbiter.sv
verilog/unified_mem.sv
verilog/rv_core_top.sv
sim/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 -Wno-fatal
TOP       := tb_rv_core
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := TB PASSED

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
